/* pss_correlator.sv */
`timescale 1ns/1ps

module pss_correlator
    import pss_pkg::*;
(
    input  logic               clk_i,
    input  logic               reset_ni,
    input  logic [PSS_LEN-1:0] taps_i,
    input  iq_sample_t         sample_i,
    input  logic               sample_valid_i,
    input  logic               corr_en_i,
    output corr_t              power_o,
    output logic               power_valid_o
);

    iq_sample_t                line_q [PSS_LEN];
    logic [$clog2(PSS_LEN):0]  fill_q;
    logic                      accept;
    logic                      acc_pend_q;
    logic signed [ACC_W-1:0]   sum_re_d;
    logic signed [ACC_W-1:0]   sum_im_d;
    logic signed [ACC_W-1:0]   sum_re_q;
    logic signed [ACC_W-1:0]   sum_im_q;
    logic                      sum_valid_q;
    logic signed [2*ACC_W-1:0] sq_re;
    logic signed [2*ACC_W-1:0] sq_im;

    assign accept = sample_valid_i && corr_en_i;

    // ------------------------------------------------
    // sample line, newest at index 0
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (accept) begin
            line_q[0] <= sample_i;
            for (int k = 1; k < PSS_LEN; k++) begin
                line_q[k] <= line_q[k-1];
            end
        end
    end

    // fill count saturates once the line is full
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            fill_q     <= '0;
            acc_pend_q <= 1'b0;
        end else begin
            if (accept && (fill_q != ($clog2(PSS_LEN) + 1)'(PSS_LEN))) begin
                fill_q <= fill_q + 1'b1;
            end
            acc_pend_q <= accept && (fill_q >= ($clog2(PSS_LEN) + 1)'(PSS_LEN - 1));
        end
    end

    // ------------------------------------------------
    // +-1 matched filter
    // ------------------------------------------------
    always_comb begin
        sum_re_d = '0;
        sum_im_d = '0;
        for (int k = 0; k < PSS_LEN; k++) begin
            if (taps_i[k]) begin
                sum_re_d = sum_re_d + ACC_W'(line_q[k].re);
                sum_im_d = sum_im_d + ACC_W'(line_q[k].im);
            end else begin
                sum_re_d = sum_re_d - ACC_W'(line_q[k].re);
                sum_im_d = sum_im_d - ACC_W'(line_q[k].im);
            end
        end
    end

    assign sq_re = sum_re_q * sum_re_q;
    assign sq_im = sum_im_q * sum_im_q;

    always_ff @(posedge clk_i) begin
        if (acc_pend_q) begin
            sum_re_q <= sum_re_d;
            sum_im_q <= sum_im_d;
        end
        if (sum_valid_q) begin
            power_o <= corr_t'(sq_re) + corr_t'(sq_im);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sum_valid_q   <= 1'b0;
            power_valid_o <= 1'b0;
        end else begin
            sum_valid_q   <= acc_pend_q;
            power_valid_o <= sum_valid_q;
        end
    end

endmodule

/* pss_detector.sv */
`timescale 1ns/1ps

module pss_detector
    import pss_pkg::*;
(
    input  logic              clk_i,
    input  logic              reset_ni,
    input  iq_sample_t        sample_i,
    input  logic              sample_valid_i,
    input  pss_mode_e         mode_i,
    input  nid2_t             requested_nid2_i,
    output nid2_result_t      result_o,

    input  logic [AXI_AW-1:0] awaddr_i,
    input  logic              awvalid_i,
    output logic              awready_o,
    input  logic [31:0]       wdata_i,
    input  logic [3:0]        wstrb_i,
    input  logic              wvalid_i,
    output logic              wready_o,
    output logic [1:0]        bresp_o,
    output logic              bvalid_o,
    input  logic              bready_i,
    input  logic [AXI_AW-1:0] araddr_i,
    input  logic              arvalid_i,
    output logic              arready_o,
    output logic [31:0]       rdata_o,
    output logic [1:0]        rresp_o,
    output logic              rvalid_o,
    input  logic              rready_i
);

    logic                corr_en;
    corr_t               power       [NUM_NID2];
    logic [NUM_NID2-1:0] power_valid;
    logic [NUM_NID2-1:0] peak;
    det_cfg_t            det_cfg;
    peak_counts_t        peak_counts;

    // ------------------------------------------------
    // one correlator and peak detector per N_id_2
    // ------------------------------------------------
    for (genvar i = 0; i < NUM_NID2; i++) begin : g_branch
        pss_correlator u_corr (
            .clk_i         (clk_i),
            .reset_ni      (reset_ni),
            .taps_i        (PSS_SEQ[i]),
            .sample_i      (sample_i),
            .sample_valid_i(sample_valid_i),
            .corr_en_i     (corr_en),
            .power_o       (power[i]),
            .power_valid_o (power_valid[i])
        );

        pss_peak_detector u_peak (
            .clk_i        (clk_i),
            .reset_ni     (reset_ni),
            .power_i      (power[i]),
            .power_valid_i(power_valid[i]),
            .cfg_i        (det_cfg),
            .peak_o       (peak[i])
        );
    end

    pss_nid2_decider u_decider (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .mode_i          (mode_i),
        .requested_nid2_i(requested_nid2_i),
        .peak_i          (peak),
        .corr_en_o       (corr_en),
        .result_o        (result_o),
        .counts_o        (peak_counts)
    );

    pss_regmap u_regmap (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .awaddr_i (awaddr_i),
        .awvalid_i(awvalid_i),
        .awready_o(awready_o),
        .wdata_i  (wdata_i),
        .wstrb_i  (wstrb_i),
        .wvalid_i (wvalid_i),
        .wready_o (wready_o),
        .bresp_o  (bresp_o),
        .bvalid_o (bvalid_o),
        .bready_i (bready_i),
        .araddr_i (araddr_i),
        .arvalid_i(arvalid_i),
        .arready_o(arready_o),
        .rdata_o  (rdata_o),
        .rresp_o  (rresp_o),
        .rvalid_o (rvalid_o),
        .rready_i (rready_i),
        .counts_i (peak_counts),
        .cfg_o    (det_cfg)
    );

endmodule

/* pss_nid2_decider.sv */
`timescale 1ns/1ps

module pss_nid2_decider
    import pss_pkg::*;
(
    input  logic                clk_i,
    input  logic                reset_ni,
    input  pss_mode_e           mode_i,
    input  nid2_t               requested_nid2_i,
    input  logic [NUM_NID2-1:0] peak_i,
    output logic                corr_en_o,
    output nid2_result_t        result_o,
    output peak_counts_t        counts_o
);

    logic  onehot;
    nid2_t hot_id;

    // single branch peaking
    always_comb begin
        onehot = 1'b1;
        hot_id = '0;
        case (peak_i)
            3'b001:  hot_id = 2'd0;
            3'b010:  hot_id = 2'd1;
            3'b100:  hot_id = 2'd2;
            default: onehot = 1'b0;
        endcase
    end

    // ------------------------------------------------
    // mode handling and result
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            corr_en_o <= 1'b0;
            result_o  <= '0;
        end else begin
            result_o.id <= hot_id;
            case (mode_i)
                SEARCH: begin
                    corr_en_o      <= 1'b1;
                    result_o.valid <= onehot;
                end
                FIND: begin
                    corr_en_o      <= 1'b1;
                    result_o.valid <= onehot && (hot_id == requested_nid2_i);
                end
                default: begin
                    corr_en_o      <= 1'b0;
                    result_o.valid <= 1'b0;
                end
            endcase
        end
    end

    // per-branch counters, wrap at CNT_W
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            counts_o <= '0;
        end else begin
            for (int i = 0; i < NUM_NID2; i++) begin
                if (peak_i[i]) begin
                    counts_o[i] <= counts_o[i] + 1'b1;
                end
            end
        end
    end

endmodule

/* pss_peak_detector.sv */
`timescale 1ns/1ps

module pss_peak_detector
    import pss_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_ni,
    input  corr_t    power_i,
    input  logic     power_valid_i,
    input  det_cfg_t cfg_i,
    output logic     peak_o
);

    corr_t                 window_q [WINDOW_LEN];
    logic [WIN_SUM_W-1:0]  sum_q;
    logic [WINDOW_SHIFT:0] fill_q;
    logic                  armed;
    corr_t                 mean;
    logic [THRESH_W-1:0]   threshold;
    logic                  hit;

    // armed once the window holds WINDOW_LEN earlier powers
    assign armed = (fill_q == (WINDOW_SHIFT + 1)'(WINDOW_LEN));

    assign mean      = corr_t'(sum_q >> WINDOW_SHIFT);
    assign threshold = THRESH_W'(mean) << cfg_i.detection_shift;

    assign hit = armed
              && (power_i > cfg_i.noise_limit)
              && (THRESH_W'(power_i) > threshold);

    // ------------------------------------------------
    // sliding window, pushed after the compare
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (power_valid_i) begin
            window_q[0] <= power_i;
            for (int k = 1; k < WINDOW_LEN; k++) begin
                window_q[k] <= window_q[k-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sum_q  <= '0;
            fill_q <= '0;
            peak_o <= 1'b0;
        end else begin
            peak_o <= power_valid_i && hit;
            if (power_valid_i) begin
                // oldest entry leaves only when the window is full
                sum_q <= sum_q + WIN_SUM_W'(power_i)
                       - (armed ? WIN_SUM_W'(window_q[WINDOW_LEN-1]) : '0);
                if (!armed) begin
                    fill_q <= fill_q + 1'b1;
                end
            end
        end
    end

endmodule

/* pss_pkg.sv */
package pss_pkg;

    // ------------------------------------------------
    // sample and correlation widths
    // ------------------------------------------------
    localparam int SAMPLE_W = 8;
    localparam int PSS_LEN  = 16;
    localparam int NUM_NID2 = 3;
    localparam int ACC_W    = 13;
    localparam int CORR_W   = 26;

    typedef struct packed {
        logic signed [SAMPLE_W-1:0] re;
        logic signed [SAMPLE_W-1:0] im;
    } iq_sample_t;

    typedef logic [CORR_W-1:0] corr_t;

    // bit k is the tap for the sample k steps old, 1 is +1 and 0 is -1
    localparam logic [NUM_NID2-1:0][PSS_LEN-1:0] PSS_SEQ = {
        16'h56E1,  // N_id_2 = 2
        16'h9C6B,  // N_id_2 = 1
        16'h3A5C   // N_id_2 = 0
    };

    // ------------------------------------------------
    // peak detection
    // ------------------------------------------------
    localparam int WINDOW_LEN   = 8;
    localparam int WINDOW_SHIFT = 3;
    localparam int DSHIFT_W     = 3;
    localparam int WIN_SUM_W    = CORR_W + WINDOW_SHIFT;
    // mean shifted by up to 7 bits
    localparam int THRESH_W     = CORR_W + 2**DSHIFT_W - 1;

    typedef struct packed {
        corr_t               noise_limit;
        logic [DSHIFT_W-1:0] detection_shift;
    } det_cfg_t;

    // ------------------------------------------------
    // decision and counters
    // ------------------------------------------------
    typedef enum logic [1:0] {
        SEARCH = 2'd0,
        FIND   = 2'd1,
        PAUSE  = 2'd2
    } pss_mode_e;

    typedef logic [1:0] nid2_t;

    typedef struct packed {
        logic  valid;
        nid2_t id;
    } nid2_result_t;

    localparam int CNT_W = 16;
    typedef logic [NUM_NID2-1:0][CNT_W-1:0] peak_counts_t;

    // ------------------------------------------------
    // register map
    // ------------------------------------------------
    localparam int AXI_AW = 5;

    localparam logic [AXI_AW-1:0] REG_ID    = 5'h00;
    localparam logic [AXI_AW-1:0] REG_NOISE = 5'h04;
    localparam logic [AXI_AW-1:0] REG_SHIFT = 5'h08;
    localparam logic [AXI_AW-1:0] REG_CNT0  = 5'h0C;
    localparam logic [AXI_AW-1:0] REG_CNT1  = 5'h10;
    localparam logic [AXI_AW-1:0] REG_CNT2  = 5'h14;

    localparam logic [31:0]         PSS_ID_VALUE = 32'h5053_5331;
    localparam corr_t               NOISE_RESET  = corr_t'(1000);
    localparam logic [DSHIFT_W-1:0] SHIFT_RESET  = 3'd3;

endpackage

/* pss_regmap.sv */
`timescale 1ns/1ps

module pss_regmap
    import pss_pkg::*;
(
    input  logic              clk_i,
    input  logic              reset_ni,

    // write address and data
    input  logic [AXI_AW-1:0] awaddr_i,
    input  logic              awvalid_i,
    output logic              awready_o,
    input  logic [31:0]       wdata_i,
    input  logic [3:0]        wstrb_i,
    input  logic              wvalid_i,
    output logic              wready_o,

    // write response
    output logic [1:0]        bresp_o,
    output logic              bvalid_o,
    input  logic              bready_i,

    // read address and data
    input  logic [AXI_AW-1:0] araddr_i,
    input  logic              arvalid_i,
    output logic              arready_o,
    output logic [31:0]       rdata_o,
    output logic [1:0]        rresp_o,
    output logic              rvalid_o,
    input  logic              rready_i,

    input  peak_counts_t      counts_i,
    output det_cfg_t          cfg_o
);

    corr_t               noise_q;
    logic [DSHIFT_W-1:0] shift_q;
    logic                wr_hs;
    logic                rd_hs;
    logic [31:0]         rd_mux;

    assign wr_hs = awready_o && awvalid_i && wvalid_i;
    assign rd_hs = arready_o && arvalid_i;

    assign bresp_o = 2'b00;
    assign rresp_o = 2'b00;

    assign cfg_o.noise_limit     = noise_q;
    assign cfg_o.detection_shift = shift_q;

    // ------------------------------------------------
    // write channel
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            noise_q   <= NOISE_RESET;
            shift_q   <= SHIFT_RESET;
        end else begin
            // one-cycle ready pulse, none while a response waits
            if (!awready_o && !bvalid_o && awvalid_i && wvalid_i) begin
                awready_o <= 1'b1;
                wready_o  <= 1'b1;
            end else begin
                awready_o <= 1'b0;
                wready_o  <= 1'b0;
            end
            if (wr_hs) begin
                bvalid_o <= 1'b1;
                if (awaddr_i == REG_NOISE) begin
                    noise_q <= wdata_i[CORR_W-1:0];
                end else if (awaddr_i == REG_SHIFT) begin
                    shift_q <= wdata_i[DSHIFT_W-1:0];
                end
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end
        end
    end

    // ------------------------------------------------
    // read channel
    // ------------------------------------------------
    always_comb begin
        case (araddr_i)
            REG_ID:    rd_mux = PSS_ID_VALUE;
            REG_NOISE: rd_mux = 32'(noise_q);
            REG_SHIFT: rd_mux = 32'(shift_q);
            REG_CNT0:  rd_mux = 32'(counts_i[0]);
            REG_CNT1:  rd_mux = 32'(counts_i[1]);
            REG_CNT2:  rd_mux = 32'(counts_i[2]);
            default:   rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
        end else begin
            arready_o <= !arready_o && !rvalid_o && arvalid_i;
            if (rd_hs) begin
                rvalid_o <= 1'b1;
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_hs) begin
            rdata_o <= rd_mux;
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -j 0 \
    --top-module tb_pss_detector -f src.f -o sim_pss
./obj_dir/sim_pss > sim.log
cat sim.log

grep -qx "test passed" sim.log

/* src.f */
+incdir+.
pss_pkg.sv
pss_correlator.sv
pss_peak_detector.sv
pss_nid2_decider.sv
pss_regmap.sv
pss_detector.sv
tb_pss_detector.sv

/* tb_pss_model.svh */
// ------------------------------------------------
// random numbers
// ------------------------------------------------
logic [15:0] lfsr_q = 16'd62034;

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
endfunction

function automatic int rand_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
        r = (r << 1) | int'(lfsr_bit());
    end
    return r;
endfunction

// ------------------------------------------------
// reference model
// ------------------------------------------------
iq_sample_t       m_hist  [PSS_LEN];
int               m_fill;
logic             m_corr_en;
longint           m_win   [NUM_NID2][WINDOW_LEN];
longint           m_wsum  [NUM_NID2];
int               m_wfill [NUM_NID2];
nid2_result_t     m_dly   [4];
logic [CNT_W-1:0] m_cnt   [NUM_NID2];

int   errors;
int   checks;
logic timed_out;

task automatic model_reset();
    m_fill    = 0;
    m_corr_en = 1'b0;
    for (int b = 0; b < NUM_NID2; b++) begin
        m_wsum[b]  = 0;
        m_wfill[b] = 0;
        m_cnt[b]   = '0;
    end
    for (int d = 0; d < 4; d++) begin
        m_dly[d] = '0;
    end
endtask

// tap k weights the sample k steps old
function automatic longint branch_power(input int b);
    longint sr;
    longint si;
    sr = 0;
    si = 0;
    for (int k = 0; k < PSS_LEN; k++) begin
        if (PSS_SEQ[b][k]) begin
            sr = sr + longint'($signed(m_hist[k].re));
            si = si + longint'($signed(m_hist[k].im));
        end else begin
            sr = sr - longint'($signed(m_hist[k].re));
            si = si - longint'($signed(m_hist[k].im));
        end
    end
    return sr * sr + si * si;
endfunction

// advances the model by one clock edge
task automatic model_edge(input iq_sample_t s, input logic v, input pss_mode_e mode,
                          input nid2_t req, input det_cfg_t cfg, output nid2_result_t exp_o);
    logic [NUM_NID2-1:0] pk;
    nid2_result_t        r;
    longint              p;
    longint              thr;
    pk = '0;
    r  = '0;
    if (v && m_corr_en) begin
        for (int k = PSS_LEN - 1; k > 0; k--) begin
            m_hist[k] = m_hist[k-1];
        end
        m_hist[0] = s;
        if (m_fill < PSS_LEN) begin
            m_fill++;
        end
        if (m_fill == PSS_LEN) begin
            for (int b = 0; b < NUM_NID2; b++) begin
                p     = branch_power(b);
                thr   = (m_wsum[b] >> WINDOW_SHIFT) << cfg.detection_shift;
                pk[b] = (m_wfill[b] == WINDOW_LEN) && (p > longint'(cfg.noise_limit))
                     && (p > thr);
                // compare first, then slide the window
                if (m_wfill[b] == WINDOW_LEN) begin
                    m_wsum[b] = m_wsum[b] - m_win[b][WINDOW_LEN-1];
                end else begin
                    m_wfill[b]++;
                end
                for (int k = WINDOW_LEN - 1; k > 0; k--) begin
                    m_win[b][k] = m_win[b][k-1];
                end
                m_win[b][0] = p;
                m_wsum[b]   = m_wsum[b] + p;
                m_cnt[b]    = m_cnt[b] + CNT_W'(pk[b]);
            end
        end
    end
    if ($countones(pk) == 1) begin
        r.id    = pk[2] ? 2'd2 : (pk[1] ? 2'd1 : 2'd0);
        r.valid = (mode == SEARCH) || ((mode == FIND) && (r.id == req));
    end
    // sample to result is four edges
    exp_o    = m_dly[3];
    m_dly[3] = m_dly[2];
    m_dly[2] = m_dly[1];
    m_dly[1] = m_dly[0];
    m_dly[0] = r;
    m_corr_en = (mode != PAUSE);
endtask

// ------------------------------------------------
// compare tasks
// ------------------------------------------------
task automatic check_result(input string name, input nid2_result_t exp,
                            input nid2_result_t act);
    if (timed_out) return;
    checks++;
    if ((exp.valid !== act.valid) || (exp.valid && (exp.id !== act.id))) begin
        errors++;
        $display("CHECK FAILED %s %s: expected valid=%0b id=%0d, actual valid=%0b id=%0d",
                 test_name, name, exp.valid, exp.id, act.valid, act.id);
    end
endtask

task automatic check_count(input string name, input logic [CNT_W-1:0] exp,
                           input logic [CNT_W-1:0] act);
    if (timed_out) return;
    checks++;
    if (exp !== act) begin
        errors++;
        $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, name, exp, act);
    end
endtask

task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (timed_out) return;
    checks++;
    if (exp !== act) begin
        errors++;
        $display("CHECK FAILED %s %s: expected 0x%08h, actual 0x%08h",
                 test_name, name, exp, act);
    end
endtask

task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (timed_out) return;
    checks++;
    if (exp !== act) begin
        errors++;
        $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, name, exp, act);
    end
endtask

/* tb_pss_detector.sv */
`timescale 1ns/1ps

module tb_pss_detector
    import pss_pkg::*;
();

    logic              clk_i;
    logic              reset_ni;
    iq_sample_t        sample_i;
    logic              sample_valid_i;
    pss_mode_e         mode_i;
    nid2_t             requested_nid2_i;
    nid2_result_t      result_o;
    logic [AXI_AW-1:0] awaddr_i;
    logic              awvalid_i;
    logic              awready_o;
    logic [31:0]       wdata_i;
    logic [3:0]        wstrb_i;
    logic              wvalid_i;
    logic              wready_o;
    logic [1:0]        bresp_o;
    logic              bvalid_o;
    logic              bready_i;
    logic [AXI_AW-1:0] araddr_i;
    logic              arvalid_i;
    logic              arready_o;
    logic [31:0]       rdata_o;
    logic [1:0]        rresp_o;
    logic              rvalid_o;
    logic              rready_i;

    det_cfg_t cur_cfg;
    string    test_name;
    int       err_mark;
    int       seen       [NUM_NID2];
    int       single_ins [NUM_NID2];
    logic [31:0] rd;

    `include "tb_pss_model.svh"

    pss_detector DUT (.*);

    always #5 clk_i = ~clk_i;

    // ------------------------------------------------
    // clocking and AXI-lite driver
    // ------------------------------------------------
    task automatic tick();
        iq_sample_t   s;
        logic         v;
        pss_mode_e    m;
        nid2_t        req;
        nid2_result_t exp_r;
        if (timed_out) return;
        s   = sample_i;
        v   = sample_valid_i;
        m   = mode_i;
        req = requested_nid2_i;
        @(posedge clk_i);
        #1;
        model_edge(s, v, m, req, cur_cfg, exp_r);
        check_result("result", exp_r, result_o);
        if (result_o.valid) seen[result_o.id]++;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not arrive within 50 cycles", what);
        timed_out = 1'b1;
    endtask

    task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [31:0] data);
        logic hs;
        int   n;
        awaddr_i  = addr;
        wdata_i   = data;
        awvalid_i = 1'b1;
        wvalid_i  = 1'b1;
        bready_i  = 1'b1;
        hs = 1'b0;
        n  = 0;
        while (!hs && n < 50 && !timed_out) begin
            hs = awready_o && wready_o;
            if (awready_o !== wready_o) begin
                errors++;
                $display("%s: awready and wready did not rise together", test_name);
            end
            tick();
            n++;
        end
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        if (!hs) begin
            report_timeout("awready");
        end else begin
            n = 0;
            while (!bvalid_o && n < 50 && !timed_out) begin
                tick();
                n++;
            end
            if (!bvalid_o) begin
                report_timeout("bvalid");
            end else begin
                check_resp("bresp", 2'b00, bresp_o);
            end
            tick();
        end
        bready_i = 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_AW-1:0] addr, output logic [31:0] data);
        logic hs;
        int   n;
        data      = '0;
        araddr_i  = addr;
        arvalid_i = 1'b1;
        rready_i  = 1'b1;
        hs = 1'b0;
        n  = 0;
        while (!hs && n < 50 && !timed_out) begin
            hs = arready_o;
            tick();
            n++;
        end
        arvalid_i = 1'b0;
        if (!hs) begin
            report_timeout("arready");
        end else begin
            n = 0;
            while (!rvalid_o && n < 50 && !timed_out) begin
                tick();
                n++;
            end
            if (!rvalid_o) begin
                report_timeout("rvalid");
            end else begin
                check_resp("rresp", 2'b00, rresp_o);
                data = rdata_o;
                tick();
            end
        end
        rready_i = 1'b0;
    endtask

    // ------------------------------------------------
    // sample stimulus
    // ------------------------------------------------
    function automatic iq_sample_t noise_sample();
        iq_sample_t        s;
        logic signed [2:0] re3;
        logic signed [2:0] im3;
        re3  = 3'(rand_bits(3));
        im3  = 3'(rand_bits(3));
        s.re = SAMPLE_W'(re3);
        s.im = SAMPLE_W'(im3);
        return s;
    endfunction

    // random gap in valid before some samples
    task automatic push_sample(input iq_sample_t s);
        if (rand_bits(2) == 0) begin
            sample_valid_i = 1'b0;
            tick();
        end
        sample_i       = s;
        sample_valid_i = 1'b1;
        tick();
        sample_valid_i = 1'b0;
    endtask

    // oldest tap goes in first
    // a negative b inserts a single sequence
    task automatic insert_seq(input int a, input int b);
        iq_sample_t s;
        int         amp;
        for (int j = PSS_LEN - 1; j >= 0; j--) begin
            amp = PSS_SEQ[a][j] ? 40 : -40;
            if (b >= 0) amp = amp + (PSS_SEQ[b][j] ? 40 : -40);
            s    = noise_sample();
            s.re = SAMPLE_W'(amp);
            push_sample(s);
        end
    endtask

    task automatic stream(input int inserts);
        int n;
        int a;
        for (int i = 0; i < inserts; i++) begin
            n = 16 + rand_bits(4);
            repeat (n) push_sample(noise_sample());
            n = rand_bits(2);
            a = rand_bits(4) % NUM_NID2;
            if (n == 3) begin
                insert_seq(a, (a + 1) % NUM_NID2);
            end else begin
                insert_seq(a, -1);
                single_ins[a]++;
            end
        end
        repeat (24) push_sample(noise_sample());
        repeat (8) tick();
    endtask

    // ------------------------------------------------
    // test bookkeeping
    // ------------------------------------------------
    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
        for (int i = 0; i < NUM_NID2; i++) begin
            seen[i]       = 0;
            single_ins[i] = 0;
        end
    endtask

    task automatic end_test();
        $display("[%s] done with %0d errors", test_name, errors - err_mark);
    endtask

    // only want_id may appear and it must appear when inserted alone
    task automatic check_reported(input int want_id);
        if (timed_out) return;
        for (int i = 0; i < NUM_NID2; i++) begin
            checks++;
            if ((want_id < 0 || want_id == i) && single_ins[i] > 0 && seen[i] == 0) begin
                errors++;
                $display("%s: N_id_2 %0d was never reported after %0d inserts",
                         test_name, i, single_ins[i]);
            end else if (want_id >= 0 && want_id != i && seen[i] > 0) begin
                errors++;
                $display("%s: N_id_2 %0d was reported while only %0d was requested",
                         test_name, i, want_id);
            end
        end
    endtask

    initial begin
        clk_i            = 1'b0;
        reset_ni         = 1'b0;
        sample_i         = '0;
        sample_valid_i   = 1'b0;
        mode_i           = SEARCH;
        requested_nid2_i = '0;
        awaddr_i         = '0;
        awvalid_i        = 1'b0;
        wdata_i          = '0;
        wstrb_i          = 4'hF;
        wvalid_i         = 1'b0;
        bready_i         = 1'b0;
        araddr_i         = '0;
        arvalid_i        = 1'b0;
        rready_i         = 1'b0;
        errors           = 0;
        checks           = 0;
        timed_out        = 1'b0;
        cur_cfg          = {NOISE_RESET, SHIFT_RESET};
        model_reset();
        repeat (16) @(posedge clk_i);
        #1;
        reset_ni = 1'b1;

        start_test("reg_reset");
        axi_read(REG_ID, rd);
        check_reg("id", PSS_ID_VALUE, rd);
        axi_read(REG_NOISE, rd);
        check_reg("noise reset", 32'(NOISE_RESET), rd);
        axi_read(REG_SHIFT, rd);
        check_reg("shift reset", 32'(SHIFT_RESET), rd);
        axi_read(5'h1C, rd);
        check_reg("unmapped", 32'h0, rd);
        end_test();

        start_test("search_random");
        stream(14);
        check_reported(-1);
        end_test();

        start_test("new_thresholds");
        axi_write(REG_NOISE, 32'd2000);
        axi_write(REG_SHIFT, 32'd2);
        cur_cfg.noise_limit     = corr_t'(2000);
        cur_cfg.detection_shift = 3'd2;
        axi_read(REG_NOISE, rd);
        check_reg("noise readback", 32'd2000, rd);
        axi_read(REG_SHIFT, rd);
        check_reg("shift readback", 32'd2, rd);
        stream(10);
        end_test();

        start_test("find_nid2_1");
        requested_nid2_i = 2'd1;
        mode_i           = FIND;
        repeat (2) tick();
        stream(12);
        check_reported(1);
        end_test();

        start_test("pause");
        mode_i = PAUSE;
        repeat (4) tick();
        stream(6);
        check_reported(3);
        end_test();

        start_test("resume");
        mode_i = SEARCH;
        repeat (2) tick();
        stream(8);
        end_test();

        start_test("counters");
        axi_read(REG_CNT0, rd);
        check_count("cnt0", m_cnt[0], rd[CNT_W-1:0]);
        axi_read(REG_CNT1, rd);
        check_count("cnt1", m_cnt[1], rd[CNT_W-1:0]);
        axi_read(REG_CNT2, rd);
        check_count("cnt2", m_cnt[2], rd[CNT_W-1:0]);
        end_test();

        $display("checks %0d, errors %0d, timeout %0b", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
